//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = loss_monitor_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# build and run, exit status follows the testbench result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/loss_monitor_tb.sv
`timescale 1ns/10ps
`default_nettype none

module loss_monitor_tb;

	import seq_pkg::*;

	localparam int tag_pos   = 2;  // tag at byte index 2
	localparam int seg_len   = 3;  // packets per tag value
	localparam int check_max = 12; // checked packets before done
	localparam int n_rows    = 18;

	// one packet and the expected counters once it has settled
	typedef struct packed {
		logic [7:0]   len;  // bytes in the packet, below 3 is a runt
		logic [7:0]   tag;  // byte placed at tag_pos
		logic [7:0]   gap;  // idle cycles after the packet
		logic [31:0]  pkt;
		logic [31:0]  ok;
		logic [31:0]  ng;
		logic [31:0]  lost;
		logic [31:0]  runt;
		logic         done;
		check_state_t st;
	} row_t;

	// ------------------------------------------------------------
	// stimulus table, expected values from the sequence rules
	// ------------------------------------------------------------
	localparam row_t rows [n_rows] = '{
		// first tag only opens the sequence
		'{8'd4, 8'd5,   8'd4, 32'd0,  32'd0, 32'd0, 32'd0,   32'd0, 1'b0, S_RUN},
		// clean run 5,5 then 6,6,6 then 7
		'{8'd5, 8'd5,   8'd4, 32'd1,  32'd1, 32'd0, 32'd0,   32'd0, 1'b0, S_RUN},
		'{8'd3, 8'd5,   8'd5, 32'd2,  32'd2, 32'd0, 32'd0,   32'd0, 1'b0, S_RUN},
		'{8'd6, 8'd6,   8'd4, 32'd3,  32'd3, 32'd0, 32'd0,   32'd0, 1'b0, S_RUN},
		'{8'd1, 8'd0,   8'd4, 32'd3,  32'd3, 32'd0, 32'd0,   32'd1, 1'b0, S_RUN}, // runt
		'{8'd4, 8'd6,   8'd4, 32'd4,  32'd4, 32'd0, 32'd0,   32'd1, 1'b0, S_RUN},
		'{8'd2, 8'd0,   8'd4, 32'd4,  32'd4, 32'd0, 32'd0,   32'd2, 1'b0, S_RUN}, // runt
		'{8'd3, 8'd6,   8'd4, 32'd5,  32'd5, 32'd0, 32'd0,   32'd2, 1'b0, S_RUN},
		'{8'd5, 8'd7,   8'd4, 32'd6,  32'd6, 32'd0, 32'd0,   32'd2, 1'b0, S_RUN},
		// 7 at rep 0 -> 9, loss 2 + 1*3
		'{8'd4, 8'd9,   8'd4, 32'd7,  32'd6, 32'd1, 32'd5,   32'd2, 1'b0, S_RUN},
		'{8'd3, 8'd9,   8'd4, 32'd8,  32'd7, 32'd1, 32'd5,   32'd2, 1'b0, S_RUN},
		'{8'd6, 8'd9,   8'd4, 32'd9,  32'd8, 32'd1, 32'd5,   32'd2, 1'b0, S_RUN},
		// fourth 9 when 10 was due, surplus repeat
		'{8'd4, 8'd9,   8'd4, 32'd10, 32'd8, 32'd2, 32'd5,   32'd2, 1'b0, S_RUN},
		// 9 at rep 0 -> 255, loss 2 + 245*3
		'{8'd5, 8'd255, 8'd4, 32'd11, 32'd8, 32'd3, 32'd742, 32'd2, 1'b0, S_RUN},
		// wrap 255 -> 1, loss 2 + 1*3, limit reached
		'{8'd4, 8'd1,   8'd4, 32'd12, 32'd8, 32'd4, 32'd747, 32'd2, 1'b1, S_DONE},
		// after done only runts count
		'{8'd4, 8'd2,   8'd5, 32'd12, 32'd8, 32'd4, 32'd747, 32'd2, 1'b1, S_DONE},
		'{8'd2, 8'd0,   8'd4, 32'd12, 32'd8, 32'd4, 32'd747, 32'd3, 1'b1, S_DONE},
		'{8'd3, 8'd3,   8'd4, 32'd12, 32'd8, 32'd4, 32'd747, 32'd3, 1'b1, S_DONE}
	};

	logic         clk;
	logic         rst;
	logic         rx_en;
	logic [7:0]   rx_data;
	check_state_t state;
	logic [31:0]  pkt_count;
	logic [31:0]  ok_count;
	logic [31:0]  ng_count;
	logic [31:0]  lost_count;
	logic [31:0]  runt_count;
	logic         done;

	logic [31:0]  lfsr;    // payload generator state
	int           cur_row; // row under test, for error lines

	loss_monitor #(
		.aux_pos   (tag_pos),
		.seg_max   (seg_len),
		.max_count (check_max)
	) i_loss_monitor (
		.clk        (clk),
		.rst        (rst),
		.rx_en      (rx_en),
		.rx_data    (rx_data),
		.state      (state),
		.pkt_count  (pkt_count),
		.ok_count   (ok_count),
		.ng_count   (ng_count),
		.lost_count (lost_count),
		.runt_count (runt_count),
		.done       (done)
	);

	// 8 ns clock
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ------------------------------------------------------------
	// payload bytes
	// ------------------------------------------------------------
	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		b = 8'h00;
		for (int k = 0; k < 8; k++) begin
			lfsr = lfsr_next(lfsr); // one step per bit
			b    = {b[6:0], lfsr[0]};
		end
	endtask

	// ------------------------------------------------------------
	// stop helpers and compare tasks
	// ------------------------------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_count(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("Error: %s got 0x%08h expected 0x%08h (row %0d)",
				name, got, exp, cur_row));
	endtask

	task automatic check_state(input check_state_t got, input check_state_t exp);
		if (got !== exp)
			abort_run($sformatf("Error: state got 0x%01h expected 0x%01h (row %0d)",
				got, exp, cur_row));
	endtask

	task automatic check_done(input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("Error: done got 0x%01h expected 0x%01h (row %0d)",
				got, exp, cur_row));
	endtask

	task automatic check_row(input row_t r);
		check_count("pkt_count", pkt_count, r.pkt);
		check_count("ok_count", ok_count, r.ok);
		check_count("ng_count", ng_count, r.ng);
		check_count("lost_count", lost_count, r.lost);
		check_count("runt_count", runt_count, r.runt);
		check_done(done, r.done);
		check_state(state, r.st);
	endtask

	// ------------------------------------------------------------
	// stream drivers, 1 ns after the edge
	// ------------------------------------------------------------
	task automatic send_packet(input logic [7:0] len, input logic [7:0] tag);
		logic [7:0] pay;
		for (int b = 0; b < int'(len); b++) begin
			@(posedge clk);
			#1;
			if (b == tag_pos)
				pay = tag; // tag only at its index
			else
				rand_byte(pay);
			rx_en   = 1'b1;
			rx_data = pay;
		end
	endtask

	task automatic idle(input logic [7:0] n);
		repeat (int'(n)) begin
			@(posedge clk);
			#1;
			rx_en   = 1'b0;
			rx_data = 8'h00;
		end
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		rst     = 1'b1;
		rx_en   = 1'b0;
		rx_data = 8'h00;
		lfsr    = 32'h25a54b0c;
		cur_row = -1; // -1 is the reset check
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		idle(8'd2);
		check_count("pkt_count", pkt_count, 32'd0);
		check_count("ok_count", ok_count, 32'd0);
		check_count("ng_count", ng_count, 32'd0);
		check_count("lost_count", lost_count, 32'd0);
		check_count("runt_count", runt_count, 32'd0);
		check_done(done, 1'b0);
		check_state(state, S_INIT);
		for (int i = 0; i < n_rows; i++) begin
			cur_row = i;
			send_packet(rows[i].len, rows[i].tag);
			idle(rows[i].gap); // settles all pipeline stages
			check_row(rows[i]);
		end
		$display("Done: no errors");
		$finish;
	end

	// watchdog, sized from the table
	initial begin
		int max_len;
		int max_gap;
		max_len = 0;
		max_gap = 0;
		for (int i = 0; i < n_rows; i++) begin
			if (int'(rows[i].len) > max_len)
				max_len = int'(rows[i].len);
			if (int'(rows[i].gap) > max_gap)
				max_gap = int'(rows[i].gap);
		end
		repeat (n_rows * (max_len + max_gap) + 100) @(posedge clk);
		abort_run("the run timed out before all packets were checked");
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+source
source/seq_pkg.sv
source/aux_decode.sv
source/seq_check.sv
source/seq_stats.sv
source/loss_monitor.sv
dv/loss_monitor_tb.sv

//--- source/aux_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "seq_defs.svh"

module aux_decode #(
	parameter int aux_pos = `SEQ_AUX_POS // tag byte index
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       rx_en,
	input  logic [7:0] rx_data,
	output logic       aux_stb,  // one cycle, tag valid
	output logic [7:0] aux,      // held until next aux_stb
	output logic       runt_stb  // one cycle, short packet ended
);

	// framing state, local to the decoder
	typedef enum logic [1:0] {
		D_IDLE = 2'd0, // between packets
		D_PKT  = 2'd1, // bytes seen, tag not yet
		D_TAG  = 2'd2  // tag byte captured
	} dec_state_t;

	localparam logic [15:0] tag_idx = 16'(aux_pos);

	dec_state_t  st;
	logic [15:0] idx;     // index of the byte on rx_data now
	logic        tag_hit; // tag byte on the bus this cycle

	assign tag_hit = rx_en && (idx == tag_idx);

	// ------------------------------------------------------------
	// byte index
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			idx <= '0;
		end else if (!rx_en) begin
			idx <= '0; // gap restarts the count
		end else if (idx != 16'hffff) begin
			idx <= idx + 16'd1; // saturate on long packets
		end
	end

	// ------------------------------------------------------------
	// framing and runt detection
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			st       <= D_IDLE;
			runt_stb <= 1'b0;
		end else begin
			runt_stb <= 1'b0;
			if (!rx_en) begin
				// packet ended before the tag byte
				if (st == D_PKT)
					runt_stb <= 1'b1;
				st <= D_IDLE;
			end else if (tag_hit) begin
				st <= D_TAG;
			end else if (st == D_IDLE) begin
				st <= D_PKT; // first byte, not the tag
			end
		end
	end

	// tag capture
	always_ff @(posedge clk) begin
		if (rst)
			aux_stb <= 1'b0;
		else
			aux_stb <= tag_hit;
	end

	always_ff @(posedge clk) begin
		if (tag_hit)
			aux <= rx_data; // no reset, qualified by aux_stb
	end

endmodule

`default_nettype wire

//--- source/loss_monitor.sv
`timescale 1ns/10ps
`default_nettype none

`include "seq_defs.svh"

module loss_monitor #(
	parameter int aux_pos   = `SEQ_AUX_POS,   // tag byte index
	parameter int seg_max   = `SEQ_SEG_MAX,   // packets per tag value
	parameter int max_count = `SEQ_MAX_COUNT  // check limit
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  rx_en,
	input  logic [7:0]            rx_data,
	output seq_pkg::check_state_t state,
	output logic [`SEQ_CNT_W-1:0] pkt_count,
	output logic [`SEQ_CNT_W-1:0] ok_count,
	output logic [`SEQ_CNT_W-1:0] ng_count,
	output logic [`SEQ_CNT_W-1:0] lost_count,
	output logic [`SEQ_CNT_W-1:0] runt_count,
	output logic                  done
);

	import seq_pkg::*;

	logic                  aux_stb;  // decode -> check
	logic [7:0]            aux;
	logic                  runt_stb; // decode -> stats
	logic                  upd;      // check -> stats
	verdict_t              verdict;
	logic [`SEQ_CNT_W-1:0] lost_add;

	// ------------------------------------------------------------
	// decode, check, result
	// ------------------------------------------------------------
	aux_decode #(.aux_pos(aux_pos)) i_aux_decode (
		.clk      (clk),
		.rst      (rst),
		.rx_en    (rx_en),
		.rx_data  (rx_data),
		.aux_stb  (aux_stb),
		.aux      (aux),
		.runt_stb (runt_stb)
	);

	seq_check #(.seg_max(seg_max)) i_seq_check (
		.clk      (clk),
		.rst      (rst),
		.aux_stb  (aux_stb),
		.aux      (aux),
		.done     (done),     // stops the checker
		.upd      (upd),
		.verdict  (verdict),
		.lost_add (lost_add),
		.state    (state)
	);

	seq_stats #(.max_count(max_count)) i_seq_stats (
		.clk        (clk),
		.rst        (rst),
		.upd        (upd),
		.verdict    (verdict),
		.lost_add   (lost_add),
		.runt_stb   (runt_stb),
		.pkt_count  (pkt_count),
		.ok_count   (ok_count),
		.ng_count   (ng_count),
		.lost_count (lost_count),
		.runt_count (runt_count),
		.done       (done)
	);

endmodule

`default_nettype wire

//--- source/seq_check.sv
`timescale 1ns/10ps
`default_nettype none

`include "seq_defs.svh"

module seq_check #(
	parameter int seg_max = `SEQ_SEG_MAX // packets per tag value
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    aux_stb,  // new tag
	input  logic [7:0]              aux,
	input  logic                    done,     // limit reached in stats
	output logic                    upd,      // one cycle, verdict valid
	output seq_pkg::verdict_t       verdict,
	output logic [`SEQ_CNT_W-1:0]   lost_add, // lost packets for this tag
	output seq_pkg::check_state_t   state
);

	import seq_pkg::*;

	localparam logic [7:0]            seg_last = 8'(seg_max - 1);
	localparam logic [`SEQ_CNT_W-1:0] seg_w    = `SEQ_CNT_W'(seg_max);

	logic [7:0]            prev;      // last tag seen
	logic [7:0]            rep;       // repeat position, 0..seg_max-1
	logic [7:0]            pred;      // expected tag
	logic                  rep_end;   // increment due on next tag
	logic [7:0]            rep_nxt;   // rep after a match
	logic                  is_ok;
	logic                  is_dup;
	logic [`SEQ_CNT_W-1:0] skip_lost; // loss estimate for a skip
	logic                  take;      // tag checked this cycle

	// ------------------------------------------------------------
	// loss estimate
	// ------------------------------------------------------------
	// rest of the current segment plus whole segments skipped,
	// tag gap taken mod 256 so 255 -> 1 counts one missing tag
	function automatic logic [`SEQ_CNT_W-1:0] calc_lost(
		input logic [7:0] tag,
		input logic [7:0] last,
		input logic [7:0] pos
	);
		logic [7:0]            gap;
		logic [`SEQ_CNT_W-1:0] rest;
		gap  = tag - last - 8'd1;                      // wraps mod 256
		rest = seg_w - `SEQ_CNT_W'(pos) - `SEQ_CNT_W'(1); // left in segment
		return rest + `SEQ_CNT_W'(gap) * seg_w;
	endfunction

	// ------------------------------------------------------------
	// prediction and classification
	// ------------------------------------------------------------
	assign rep_end   = (rep == seg_last);
	assign pred      = rep_end ? prev + 8'd1 : prev; // mod 256
	assign rep_nxt   = rep_end ? 8'd0 : rep + 8'd1;
	assign is_ok     = (aux == pred);
	assign is_dup    = (aux == prev);  // only reached when increment was due
	assign skip_lost = calc_lost(aux, prev, rep);

	// stats raises done one cycle after upd, so check it first
	assign take = aux_stb && (state == S_RUN) && !done;

	// ------------------------------------------------------------
	// state machine
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_INIT;
			rep   <= 8'd0;
		end else begin
			case (state)
				S_INIT: begin
					if (aux_stb) begin
						rep   <= 8'd0; // first tag opens a segment
						state <= S_RUN;
					end
				end
				S_RUN: begin
					if (done) begin
						state <= S_DONE; // stop, ignore this and later tags
					end else if (aux_stb) begin
						if (is_ok)
							rep <= rep_nxt;
						else
							rep <= 8'd0; // resync on any mismatch
					end
				end
				S_DONE: ; // hold
				default: state <= S_INIT;
			endcase
		end
	end

	// previous tag, payload only
	always_ff @(posedge clk) begin
		if (aux_stb && (state == S_INIT || take))
			prev <= aux;
	end

	// ------------------------------------------------------------
	// update strobe and result
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst)
			upd <= 1'b0;
		else
			upd <= take; // never for the first tag
	end

	always_ff @(posedge clk) begin
		if (take) begin
			if (is_ok) begin
				verdict  <= V_OK;
				lost_add <= '0;
			end else if (is_dup) begin
				verdict  <= V_DUP; // surplus repeat
				lost_add <= '0;
			end else begin
				verdict  <= V_SKIP;
				lost_add <= skip_lost;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/seq_defs.svh
`ifndef SEQ_DEFS_SVH
`define SEQ_DEFS_SVH

// ------------------------------------------------------------
// loss monitor defaults
// ------------------------------------------------------------

// byte index of the sequence tag inside a packet
`define SEQ_AUX_POS 0

// packets sent per tag value before it increments, 1..255
`define SEQ_SEG_MAX 50

// checked packets before the checker stops
`define SEQ_MAX_COUNT 500000

// width of every statistics counter
`define SEQ_CNT_W 32

`endif

//--- source/seq_pkg.sv
`default_nettype none

package seq_pkg;

	// ------------------------------------------------------------
	// checker state
	// ------------------------------------------------------------
	typedef enum logic [1:0] {
		S_INIT = 2'd0, // waiting for first tag
		S_RUN  = 2'd1, // checking tags
		S_DONE = 2'd2  // limit reached, tags ignored
	} check_state_t;

	// ------------------------------------------------------------
	// verdict for one checked tag
	// ------------------------------------------------------------
	// skip means packets went missing
	// dup is a surplus repeat of the previous tag, no loss
	typedef enum logic [1:0] {
		V_OK   = 2'd0, // as predicted
		V_SKIP = 2'd1, // jumped ahead
		V_DUP  = 2'd2  // repeat when increment was due
	} verdict_t;

endpackage

`default_nettype wire

//--- source/seq_stats.sv
`timescale 1ns/10ps
`default_nettype none

`include "seq_defs.svh"

module seq_stats #(
	parameter int max_count = `SEQ_MAX_COUNT // checked packets until done
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  upd,        // one cycle, verdict valid
	input  seq_pkg::verdict_t     verdict,
	input  logic [`SEQ_CNT_W-1:0] lost_add,
	input  logic                  runt_stb,   // short packet seen
	output logic [`SEQ_CNT_W-1:0] pkt_count,
	output logic [`SEQ_CNT_W-1:0] ok_count,
	output logic [`SEQ_CNT_W-1:0] ng_count,
	output logic [`SEQ_CNT_W-1:0] lost_count,
	output logic [`SEQ_CNT_W-1:0] runt_count,
	output logic                  done        // sticky
);

	import seq_pkg::*;

	localparam logic [`SEQ_CNT_W-1:0] pkt_last = `SEQ_CNT_W'(max_count - 1);

	// ------------------------------------------------------------
	// checked packet counters
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			pkt_count  <= '0;
			ok_count   <= '0;
			ng_count   <= '0;
			lost_count <= '0;
			done       <= 1'b0;
		end else if (upd) begin
			pkt_count  <= pkt_count + `SEQ_CNT_W'(1);
			lost_count <= lost_count + lost_add; // zero unless skip
			if (verdict == V_OK)
				ok_count <= ok_count + `SEQ_CNT_W'(1);
			else
				ng_count <= ng_count + `SEQ_CNT_W'(1); // skip or dup
			// rises with the update that reaches the limit
			if (pkt_count == pkt_last)
				done <= 1'b1;
		end
	end

	// ------------------------------------------------------------
	// runt counter
	// ------------------------------------------------------------
	// keeps counting after done
	always_ff @(posedge clk) begin
		if (rst)
			runt_count <= '0;
		else if (runt_stb)
			runt_count <= runt_count + `SEQ_CNT_W'(1);
	end

endmodule

`default_nettype wire
